//--- Bender.yml
package:
  name: i2c_master

sources:
  - hdl/i2c_pkg.sv
  - hdl/i2c_req_ingress.sv
  - hdl/i2c_xfer_seq.sv
  - hdl/i2c_bit_shift.sv
  - hdl/i2c_rsp_egress.sv
  - hdl/i2c_master_top.sv
  - target: test
    files:
      - dv/i2c_slave_model.sv
      - dv/tb_i2c_master.sv

//--- dv/i2c_slave_model.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_slave_model #(
	parameter logic [6:0] DEV_ADDR = 7'h3c
) (
	input  wire scl_i,
	inout  wire sda_io,
	output int  start_cnt_o,
	output int  stop_cnt_o
);

	bit [7:0] regs [256];                  // register file, zero at start
	bit [7:0] ptr;                         // register pointer
	bit [7:0] shift;                       // incoming byte
	bit [7:0] tx;                          // outgoing byte
	int       bit_cnt;                     // scl rises in this byte
	int       byte_idx;                    // bytes since start
	bit       active;                      // addressed, or not yet decided
	bit       in_frame;                    // between start and stop
	bit       rd_mode;                     // read bit in address
	bit       reading;
	bit       m_nack;                      // master ack bit after read byte
	bit       sda_low;

	assign sda_io = sda_low ? 1'b0 : 1'bz;

	// sda falling with scl high
	always @(negedge sda_io) begin
		if (scl_i === 1'b1) begin
			start_cnt_o = start_cnt_o + 1;
			in_frame    = 1'b1;
			active      = 1'b1;
			reading     = 1'b0;
			rd_mode     = 1'b0;
			bit_cnt     = 0;
			byte_idx    = 0;
			sda_low     = 1'b0;
		end
	end

	// sda rising with scl high
	always @(posedge sda_io) begin
		if (scl_i === 1'b1 && in_frame) begin
			stop_cnt_o = stop_cnt_o + 1;
			in_frame   = 1'b0;
			active     = 1'b0;
			sda_low    = 1'b0;
		end
	end

	always @(posedge scl_i) begin
		if (active) begin
			if (!reading && bit_cnt < 8) shift = {shift[6:0], sda_io};  // msb first
			if (reading && bit_cnt == 8) m_nack = (sda_io !== 1'b0);
			bit_cnt++;
		end
	end

	always @(negedge scl_i) begin
		if (active && bit_cnt == 8 && !reading) begin
			sda_low = 1'b1;                    // ack by default
			if (byte_idx == 0) begin
				rd_mode = shift[0];
				if (shift[7:1] != DEV_ADDR) begin
					sda_low = 1'b0;            // not ours, stay off the bus
					active  = 1'b0;
				end
			end else if (byte_idx == 1) begin
				ptr = shift;                   // register address
			end else begin
				regs[ptr] = shift;
				ptr++;
			end
			byte_idx++;
		end else if (active && bit_cnt == 9) begin
			sda_low = 1'b0;                    // ack bit over
			bit_cnt = 0;
			if (reading && m_nack) begin
				active = 1'b0;                 // wait for stop
			end else if (reading || rd_mode) begin
				if (reading) ptr++;
				reading = 1'b1;
				tx      = regs[ptr];
				sda_low = !tx[7];
			end
		end else if (active && reading && bit_cnt < 8) begin
			sda_low = !tx[7 - bit_cnt];        // next bit while scl low
		end else if (active && reading) begin
			sda_low = 1'b0;                    // master owns ack bit
		end
	end

endmodule

`default_nettype wire

//--- dv/tb_i2c_master.sv
`timescale 1ns/10ps
`default_nettype none

module tb_i2c_master import i2c_pkg::*; ();

	localparam logic [6:0] SLV_ADDR  = 7'h3c;
	localparam logic [6:0] NONE_ADDR = 7'h51;     // nobody answers here
	localparam int         TIMEOUT   = 20000;     // cycles per wait

	logic        Clk;
	logic        Rst_n;
	logic        req_valid_i;
	i2c_req_t    req_i;
	logic        req_credit_o;
	logic        rsp_credit_i;
	logic        rsp_valid_o;
	i2c_rsp_t    rsp_o;
	wire         scl;
	wire         sda;
	int          starts;                          // from slave model
	int          stops;
	logic [31:0] lfsr = 32'h95a9;
	bit   [7:0]  ref_regs [256];                  // expected slave contents
	i2c_rsp_t    exp_q [$];                       // responses still due, in order
	i2c_rsp_t    got_q [$];
	int          credit_ret;                      // req_credit_o pulses seen
	int          req_sent;
	int          errors;
	int          checks;
	int          tests;
	int          test_err;                        // errors before current test
	logic        hold_rsp;                        // response credits withheld

	i2c_master_top i_dut (
		.Clk          (Clk),
		.Rst_n        (Rst_n),
		.req_valid_i  (req_valid_i),
		.req_i        (req_i),
		.req_credit_o (req_credit_o),
		.rsp_credit_i (rsp_credit_i),
		.rsp_valid_o  (rsp_valid_o),
		.rsp_o        (rsp_o),
		.scl_o        (scl),
		.sda_io       (sda)
	);

	pullup (sda);

	i2c_slave_model #(.DEV_ADDR(SLV_ADDR)) i_slave (
		.scl_i       (scl),
		.sda_io      (sda),
		.start_cnt_o (starts),
		.stop_cnt_o  (stops)
	);

	initial begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;
	end

	// outputs sampled at the rising edge before the registers update
	always @(posedge Clk) begin
		if (req_credit_o === 1'b1) credit_ret++;
		if (rsp_valid_o === 1'b1) got_q.push_back(rsp_o);
	end

	assert property (@(posedge Clk) disable iff (!Rst_n) !(hold_rsp && rsp_valid_o))
		else begin
			$display("response sent while response credits were withheld");
			errors++;
		end

	// galois form with taps x^32+x^22+x^2+x+1
	function automatic logic lfsr_bit();
		logic lsb;
		lsb  = lfsr[0];
		lfsr = lfsr >> 1;
		if (lsb) lfsr = lfsr ^ 32'h8020_0003;
		return lsb;
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int k = 0; k < n; k++) v = {v[6:0], lfsr_bit()};
		return v;
	endfunction

	task automatic check_val(input string name, input int want, input int act);
		checks++;
		assert (act == want) else begin
			$display("mismatch %s expected %0d actual %0d", name, want, act);
			errors++;
		end
	endtask

	// called at a falling edge, returns at the next one
	task automatic send_req(input logic rnw, input logic [6:0] dev, input logic [7:0] addr,
			input logic [7:0] data);
		i2c_rsp_t want;
		int       t = 0;
		while (REQ_DEPTH + credit_ret - req_sent <= 0 && t < TIMEOUT) begin
			@(negedge Clk);
			t++;
		end
		if (REQ_DEPTH + credit_ret - req_sent <= 0) begin
			$display("timeout waiting for a request credit");
			errors++;
		end
		req_valid_i = 1'b1;
		req_i       = '{rnw: rnw, dev_addr: dev, reg_addr: addr, wdata: data};
		req_sent++;
		want = '{rnw: rnw, nack: (dev != SLV_ADDR), rdata: 8'h00};
		if (dev == SLV_ADDR && rnw) want.rdata = ref_regs[addr];
		else if (dev == SLV_ADDR) ref_regs[addr] = data;
		exp_q.push_back(want);
		@(negedge Clk);
		req_valid_i = 1'b0;
	endtask

	// grant one credit per due response, then check them in order
	task automatic collect(input string name);
		i2c_rsp_t want;
		i2c_rsp_t got;
		int       t;
		rsp_credit_i = 1'b1;
		repeat (exp_q.size()) @(negedge Clk);
		rsp_credit_i = 1'b0;
		while (exp_q.size() > 0) begin
			t = 0;
			while (got_q.size() == 0 && t < TIMEOUT) begin
				@(negedge Clk);
				t++;
			end
			if (got_q.size() == 0) begin
				$display("timeout waiting for a response in test %s", name);
				errors++;
				exp_q.delete();
			end else begin
				got  = got_q.pop_front();
				want = exp_q.pop_front();
				checks++;
				assert (got === want) else begin
					$display("mismatch %s expected %h actual %h", name, want, got);
					errors++;
				end
			end
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_err) $display("test %s passed", name);
		else $display("test %s failed with %0d errors", name, errors - test_err);
		test_err = errors;
	endtask

	initial begin
		logic [7:0] a;
		logic [7:0] d;
		int         s0;
		int         p0;
		int         c0;
		int         t;
		Rst_n        = 1'b0;
		req_valid_i  = 1'b0;
		req_i        = '0;
		rsp_credit_i = 1'b0;
		hold_rsp     = 1'b0;
		repeat (16) @(negedge Clk);
		Rst_n = 1'b1;
		@(negedge Clk);

		check_val("idle scl", 1, int'(scl));
		check_val("idle sda", 1, int'(sda));
		repeat (50) begin
			@(negedge Clk);
			check_val("idle outputs", 0, int'({req_credit_o, rsp_valid_o}));
		end
		end_test("idle");

		d = rand_bits(8);
		send_req(1'b0, SLV_ADDR, 8'h5a, d);
		collect("write_read");
		send_req(1'b1, SLV_ADDR, 8'h5a, 8'h00);   // expects d back
		collect("write_read");
		end_test("write_read");

		s0 = starts;
		p0 = stops;
		send_req(1'b0, SLV_ADDR, 8'h21, rand_bits(8));
		collect("framing");
		check_val("write starts", 1, starts - s0);
		check_val("write stops", 1, stops - p0);
		s0 = starts;
		p0 = stops;
		send_req(1'b1, SLV_ADDR, 8'h21, 8'h00);
		collect("framing");
		check_val("read starts", 2, starts - s0);  // start plus repeated start
		check_val("read stops", 1, stops - p0);
		end_test("framing");

		p0 = stops;
		send_req(1'b0, NONE_ADDR, 8'h01, 8'h77);
		collect("absent");
		check_val("absent write stops", 1, stops - p0);
		p0 = stops;
		send_req(1'b1, NONE_ADDR, 8'h02, 8'h00);
		collect("absent");
		check_val("absent read stops", 1, stops - p0);
		end_test("absent");

		hold_rsp = 1'b1;
		c0       = credit_ret;
		send_req(1'b0, SLV_ADDR, 8'h10, rand_bits(8));   // back to back
		send_req(1'b1, SLV_ADDR, 8'h10, 8'h00);
		send_req(1'b0, SLV_ADDR, 8'h11, rand_bits(8));
		send_req(1'b1, SLV_ADDR, 8'h11, 8'h00);
		t = 0;
		while (credit_ret - c0 < 2 && t < TIMEOUT) begin
			@(negedge Clk);
			t++;
		end
		if (credit_ret - c0 < 2) begin
			$display("timeout waiting for the second request to be taken");
			errors++;
		end
		repeat (4000) @(negedge Clk);                    // longer than one read
		check_val("responses while held", 0, got_q.size());
		check_val("credits while held", 2, credit_ret - c0);  // egress and sequencer full
		hold_rsp = 1'b0;
		collect("credits");
		check_val("credits returned", REQ_DEPTH, credit_ret - c0);
		end_test("credits");

		for (int i = 0; i < 20; i++) begin
			a = 8'h20 | rand_bits(4);                   // small range so reads hit writes
			d = rand_bits(8);
			send_req(lfsr_bit(), SLV_ADDR, a, d);
			collect("random");
		end
		end_test("random");

		$display("tests %0d  checks %0d  errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/i2c_bit_shift.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_bit_shift import i2c_pkg::*; (
	input  wire            Clk,
	input  wire            Rst_n,
	input  wire i2c_cmd_t  cmd_i,           // stable while busy
	input  wire            go_i,
	input  wire  [7:0]     tx_byte_i,
	output logic [7:0]     rx_byte_o,
	output logic           done_o,
	output logic           ack_bit_o,       // 1 means nack seen
	output logic           scl_o,
	inout  wire            sda_io
);

	logic [DIV_W-1:0] div_cnt;              // quarter period divider
	logic             div_en;
	logic             tick;                 // quarter period elapsed
	logic [BS_W-1:0]  state;
	logic [4:0]       cnt;                  // quarter index in state
	logic [4:0]       last_q;
	logic             last;
	logic             sda_drv;              // 0 pulls the line low
	logic             sda_oe;

	assign sda_io = (sda_oe && !sda_drv) ? 1'b0 : 1'bz;   // open drain
	assign tick   = (div_cnt == DIV_W'(SCL_QUARTER));
	assign last_q = (state == BS_WR || state == BS_RD) ? 5'd31 : 5'd3;
	assign last   = tick && (cnt == last_q);

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			div_cnt <= '0;
		end else if (div_en && !tick) begin
			div_cnt <= div_cnt + 1'b1;
		end else begin
			div_cnt <= '0;
		end
	end

	always_ff @(posedge Clk) begin
		if (state == BS_RD && tick && cnt[1:0] == 2'd2) begin
			rx_byte_o <= {rx_byte_o[6:0], sda_io};   // msb first, scl high
		end
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			state     <= BS_IDLE;
			cnt       <= '0;
			div_en    <= 1'b0;
			scl_o     <= 1'b1;
			sda_drv   <= 1'b1;
			sda_oe    <= 1'b0;
			done_o    <= 1'b0;
			ack_bit_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (tick) begin
				cnt <= last ? '0 : cnt + 1'b1;
			end
			case (state)
				BS_IDLE: begin
					div_en <= go_i;
					if (go_i) begin
						if (cmd_i.sta) state <= BS_STA;
						else if (cmd_i.wr) state <= BS_WR;
						else if (cmd_i.rd) state <= BS_RD;
						else if (cmd_i.sto) state <= BS_STO;  // standalone stop
					end
				end
				BS_STA: begin
					if (tick) begin
						case (cnt[1:0])
							2'd0: begin
								sda_drv <= 1'b1;              // release for repeated start
								sda_oe  <= 1'b1;
							end
							2'd1:    scl_o   <= 1'b1;
							2'd2:    sda_drv <= 1'b0;         // sda falls, scl high
							default: scl_o   <= 1'b0;
						endcase
					end
					if (last) begin
						if (cmd_i.wr) state <= BS_WR;
						else if (cmd_i.rd) state <= BS_RD;
						else begin
							state  <= BS_IDLE;
							div_en <= 1'b0;
							done_o <= 1'b1;
						end
					end
				end
				BS_WR: begin
					if (tick) begin
						case (cnt[1:0])
							2'd0: begin
								sda_drv <= tx_byte_i[3'd7 - cnt[4:2]];  // set bit, scl low
								sda_oe  <= 1'b1;
							end
							2'd1:    scl_o <= 1'b1;
							2'd2:    scl_o <= 1'b1;
							default: scl_o <= 1'b0;
						endcase
					end
					if (last) state <= BS_CHK;
				end
				BS_RD: begin
					if (tick) begin
						case (cnt[1:0])
							2'd0:    sda_oe <= 1'b0;         // slave drives
							2'd1:    scl_o  <= 1'b1;
							2'd2:    scl_o  <= 1'b1;
							default: scl_o  <= 1'b0;
						endcase
					end
					if (last) state <= BS_ACK;
				end
				BS_CHK: begin
					if (tick) begin
						case (cnt[1:0])
							2'd0:    sda_oe    <= 1'b0;
							2'd1:    scl_o     <= 1'b1;
							2'd2:    ack_bit_o <= sda_io;    // high means nack
							default: scl_o     <= 1'b0;
						endcase
					end
					if (last) begin
						if (cmd_i.sto) state <= BS_STO;
						else begin
							state  <= BS_IDLE;
							div_en <= 1'b0;
							done_o <= 1'b1;
						end
					end
				end
				BS_ACK: begin
					if (tick) begin
						case (cnt[1:0])
							2'd0: begin
								sda_oe  <= 1'b1;
								sda_drv <= cmd_i.nack || !cmd_i.ack;  // nack leaves line high
							end
							2'd1:    scl_o <= 1'b1;
							2'd2:    scl_o <= 1'b1;
							default: scl_o <= 1'b0;
						endcase
					end
					if (last) begin
						if (cmd_i.sto) state <= BS_STO;
						else begin
							state  <= BS_IDLE;
							div_en <= 1'b0;
							done_o <= 1'b1;
						end
					end
				end
				BS_STO: begin
					if (tick) begin
						case (cnt[1:0])
							2'd0: begin
								sda_drv <= 1'b0;              // low while scl low
								sda_oe  <= 1'b1;
							end
							2'd1:    scl_o   <= 1'b1;
							2'd2:    sda_drv <= 1'b1;         // sda rises, scl high
							default: scl_o   <= 1'b1;         // bus left idle
						endcase
					end
					if (last) begin
						state  <= BS_IDLE;
						div_en <= 1'b0;
						done_o <= 1'b1;
					end
				end
				default: state <= BS_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/i2c_master_top.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_master_top import i2c_pkg::*; (
	input  wire            Clk,
	input  wire            Rst_n,
	input  wire            req_valid_i,
	input  wire i2c_req_t  req_i,
	output logic           req_credit_o,
	input  wire            rsp_credit_i,
	output logic           rsp_valid_o,
	output i2c_rsp_t       rsp_o,
	output logic           scl_o,
	inout  wire            sda_io
);

	logic       head_valid;
	i2c_req_t   head_req;
	logic       head_pop;
	i2c_cmd_t   cmd;                       // sequencer to bit engine
	logic       go;
	logic [7:0] tx_byte;
	logic [7:0] rx_byte;
	logic       done;
	logic       ack_bit;
	logic       rsp_free;
	logic       rsp_push;
	i2c_rsp_t   rsp;

	i2c_req_ingress i_ingress (
		.Clk          (Clk),
		.Rst_n        (Rst_n),
		.req_valid_i  (req_valid_i),
		.req_i        (req_i),
		.head_pop_i   (head_pop),
		.head_valid_o (head_valid),
		.head_req_o   (head_req),
		.req_credit_o (req_credit_o)
	);

	i2c_xfer_seq i_seq (
		.Clk          (Clk),
		.Rst_n        (Rst_n),
		.head_valid_i (head_valid),
		.head_req_i   (head_req),
		.head_pop_o   (head_pop),
		.cmd_o        (cmd),
		.go_o         (go),
		.tx_byte_o    (tx_byte),
		.done_i       (done),
		.ack_bit_i    (ack_bit),
		.rx_byte_i    (rx_byte),
		.rsp_free_i   (rsp_free),
		.rsp_push_o   (rsp_push),
		.rsp_o        (rsp)
	);

	i2c_bit_shift i_bit (
		.Clk          (Clk),
		.Rst_n        (Rst_n),
		.cmd_i        (cmd),
		.go_i         (go),
		.tx_byte_i    (tx_byte),
		.rx_byte_o    (rx_byte),
		.done_o       (done),
		.ack_bit_o    (ack_bit),
		.scl_o        (scl_o),
		.sda_io       (sda_io)
	);

	i2c_rsp_egress i_egress (
		.Clk          (Clk),
		.Rst_n        (Rst_n),
		.rsp_push_i   (rsp_push),
		.rsp_i        (rsp),
		.rsp_free_o   (rsp_free),
		.rsp_credit_i (rsp_credit_i),
		.rsp_valid_o  (rsp_valid_o),
		.rsp_o        (rsp_o)
	);

endmodule

`default_nettype wire

//--- hdl/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

	localparam int SYS_CLK_HZ   = 25_000_000;
	localparam int SCL_HZ       = 400_000;
	localparam int SCL_QUARTER  = SYS_CLK_HZ / SCL_HZ / 4 - 1;  // 14 at 25 MHz
	localparam int DIV_W        = $clog2(SCL_QUARTER + 1);

	localparam int REQ_DEPTH    = 4;                 // also initial requester credits
	localparam int REQ_PTR_W    = $clog2(REQ_DEPTH);
	localparam int RSP_CREDIT_W = 4;
	localparam logic [RSP_CREDIT_W-1:0] RSP_CREDIT_MAX = '1;  // saturation point

	localparam logic [2:0] WR_STEPS = 3'd3;          // addr, reg, data+stop
	localparam logic [2:0] RD_STEPS = 3'd4;          // addr, reg, re-start addr, read+stop

	// one-hot bit engine states
	localparam int BS_W = 7;
	localparam logic [BS_W-1:0] BS_IDLE = 7'b0000001;
	localparam logic [BS_W-1:0] BS_STA  = 7'b0000010;
	localparam logic [BS_W-1:0] BS_WR   = 7'b0000100;
	localparam logic [BS_W-1:0] BS_RD   = 7'b0001000;
	localparam logic [BS_W-1:0] BS_CHK  = 7'b0010000;  // ack check after write
	localparam logic [BS_W-1:0] BS_ACK  = 7'b0100000;  // ack/nack after read
	localparam logic [BS_W-1:0] BS_STO  = 7'b1000000;

	// sequencer states
	localparam logic [1:0] SQ_IDLE  = 2'd0;
	localparam logic [1:0] SQ_ISSUE = 2'd1;
	localparam logic [1:0] SQ_WAIT  = 2'd2;
	localparam logic [1:0] SQ_RSP   = 2'd3;

	typedef struct packed {
		logic       rnw;       // 1 for read
		logic [6:0] dev_addr;
		logic [7:0] reg_addr;
		logic [7:0] wdata;     // unused on reads
	} i2c_req_t;

	typedef struct packed {
		logic       rnw;       // echo of request
		logic       nack;      // some byte not acknowledged
		logic [7:0] rdata;
	} i2c_rsp_t;

	typedef struct packed {
		logic sta;
		logic wr;
		logic rd;
		logic sto;
		logic ack;
		logic nack;
	} i2c_cmd_t;

	localparam i2c_cmd_t CMD_STOP = '{sto: 1'b1, default: 1'b0};  // abort stop

endpackage

`default_nettype wire

//--- hdl/i2c_req_ingress.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_req_ingress import i2c_pkg::*; (
	input  wire            Clk,
	input  wire            Rst_n,
	input  wire            req_valid_i,
	input  wire i2c_req_t  req_i,
	input  wire            head_pop_i,
	output logic           head_valid_o,
	output i2c_req_t       head_req_o,
	output logic           req_credit_o
);

	i2c_req_t             mem [REQ_DEPTH];  // request storage
	logic [REQ_PTR_W-1:0] wr_ptr;
	logic [REQ_PTR_W-1:0] rd_ptr;
	logic [REQ_PTR_W:0]   count;            // occupancy
	logic                 pop;

	assign head_valid_o = (count != '0);
	assign head_req_o   = mem[rd_ptr];      // oldest entry
	assign pop          = head_pop_i && head_valid_o;

	always_ff @(posedge Clk) begin
		if (req_valid_i) begin
			mem[wr_ptr] <= req_i;           // sender holds a credit so never full
		end
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (req_valid_i) begin
				wr_ptr <= (wr_ptr == REQ_PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == REQ_PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			count <= '0;
		end else begin
			case ({req_valid_i, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;        // both or neither
			endcase
		end
	end

	// one credit back per freed slot
	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			req_credit_o <= 1'b0;
		end else begin
			req_credit_o <= pop;
		end
	end

endmodule

`default_nettype wire

//--- hdl/i2c_rsp_egress.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_rsp_egress import i2c_pkg::*; (
	input  wire            Clk,
	input  wire            Rst_n,
	input  wire            rsp_push_i,
	input  wire i2c_rsp_t  rsp_i,
	output logic           rsp_free_o,
	input  wire            rsp_credit_i,
	output logic           rsp_valid_o,
	output i2c_rsp_t       rsp_o
);

	i2c_rsp_t                rsp_q;        // holding register
	logic                    full_q;
	logic [RSP_CREDIT_W-1:0] credits;      // granted by consumer
	logic                    send;

	assign send        = full_q && (credits != '0);
	assign rsp_valid_o = send;             // one cycle, entry clears after
	assign rsp_o       = rsp_q;
	assign rsp_free_o  = !full_q;

	always_ff @(posedge Clk) begin
		if (rsp_push_i) begin
			rsp_q <= rsp_i;
		end
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			full_q <= 1'b0;
		end else if (rsp_push_i) begin
			full_q <= 1'b1;                  // push only while free
		end else if (send) begin
			full_q <= 1'b0;
		end
	end

	// grant and spend in one cycle cancel out
	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			credits <= '0;
		end else if (rsp_credit_i && !send && credits != RSP_CREDIT_MAX) begin
			credits <= credits + 1'b1;
		end else if (send && !rsp_credit_i) begin
			credits <= credits - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/i2c_xfer_seq.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_xfer_seq import i2c_pkg::*; (
	input  wire            Clk,
	input  wire            Rst_n,
	input  wire            head_valid_i,
	input  wire i2c_req_t  head_req_i,
	output logic           head_pop_o,
	output i2c_cmd_t       cmd_o,          // held until next go
	output logic           go_o,
	output logic [7:0]     tx_byte_o,
	input  wire            done_i,
	input  wire            ack_bit_i,
	input  wire  [7:0]     rx_byte_i,
	input  wire            rsp_free_i,
	output logic           rsp_push_o,
	output i2c_rsp_t       rsp_o
);

	logic [1:0] state;
	logic [2:0] step;                      // index of next command to issue
	logic [2:0] n_steps;
	i2c_req_t   req_q;
	logic       nack_q;
	logic [7:0] rdata_q;
	i2c_cmd_t   nxt_cmd;
	logic [7:0] nxt_tx;

	assign n_steps = req_q.rnw ? RD_STEPS : WR_STEPS;
	assign rsp_o   = '{rnw: req_q.rnw, nack: nack_q, rdata: rdata_q};

	// command list per step
	always_comb begin
		nxt_cmd = '0;
		nxt_tx  = req_q.reg_addr;
		case (step)
			3'd0: begin
				nxt_cmd.sta = 1'b1;
				nxt_cmd.wr  = 1'b1;
				nxt_tx      = {req_q.dev_addr, 1'b0};   // address, write bit
			end
			3'd1: nxt_cmd.wr = 1'b1;                 // register address
			3'd2: begin
				nxt_cmd.wr = 1'b1;
				if (req_q.rnw) begin
					nxt_cmd.sta = 1'b1;                 // repeated start
					nxt_tx      = {req_q.dev_addr, 1'b1};
				end else begin
					nxt_cmd.sto = 1'b1;
					nxt_tx      = req_q.wdata;
				end
			end
			default: begin
				nxt_cmd.rd   = 1'b1;                    // single byte, nack, stop
				nxt_cmd.nack = 1'b1;
				nxt_cmd.sto  = 1'b1;
			end
		endcase
	end

	always_ff @(posedge Clk) begin
		if (state == SQ_IDLE && head_valid_i) begin
			req_q <= head_req_i;
		end
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			state      <= SQ_IDLE;
			step       <= '0;
			nack_q     <= 1'b0;
			rdata_q    <= '0;
			cmd_o      <= '0;
			tx_byte_o  <= '0;
			go_o       <= 1'b0;
			head_pop_o <= 1'b0;
			rsp_push_o <= 1'b0;
		end else begin
			go_o       <= 1'b0;
			head_pop_o <= 1'b0;
			rsp_push_o <= 1'b0;
			case (state)
				SQ_IDLE: begin
					if (head_valid_i) begin
						head_pop_o <= 1'b1;
						nack_q     <= 1'b0;
						rdata_q    <= '0;
						step       <= '0;
						state      <= SQ_ISSUE;
					end
				end
				SQ_ISSUE: begin
					go_o      <= 1'b1;
					cmd_o     <= nxt_cmd;
					tx_byte_o <= nxt_tx;
					step      <= step + 1'b1;
					state     <= SQ_WAIT;
				end
				SQ_WAIT: begin
					if (done_i) begin
						if (cmd_o.rd) begin
							rdata_q <= rx_byte_i;
						end
						if (cmd_o.wr && ack_bit_i) begin
							nack_q <= 1'b1;
							step   <= n_steps;             // nothing more after abort
							if (cmd_o.sto) begin
								state <= SQ_RSP;           // bus already stopped
							end else begin
								go_o  <= 1'b1;
								cmd_o <= CMD_STOP;
							end
						end else if (step == n_steps) begin
							state <= SQ_RSP;
						end else begin
							go_o      <= 1'b1;
							cmd_o     <= nxt_cmd;
							tx_byte_o <= nxt_tx;
							step      <= step + 1'b1;
						end
					end
				end
				default: begin
					if (rsp_free_i) begin
						rsp_push_o <= 1'b1;              // egress takes rsp_o now
						state      <= SQ_IDLE;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- sim.f
hdl/i2c_pkg.sv
hdl/i2c_req_ingress.sv
hdl/i2c_xfer_seq.sv
hdl/i2c_bit_shift.sv
hdl/i2c_rsp_egress.sv
hdl/i2c_master_top.sv
dv/i2c_slave_model.sv
dv/tb_i2c_master.sv
